//--- nemesis_pkg.sv
`default_nettype none

package nemesis_pkg;

	////////////////////////////////////////
	// Widths
	////////////////////////////////////////

	localparam int DATA_W    = 16;
	localparam int BYTE_W    = 8;
	localparam int PAL_IDX_W = 11;           // 2K palette words
	localparam int PAL_WORDS = 1 << PAL_IDX_W;
	localparam int COLOR_W   = 5;

	typedef logic [15:1]          word_addr_t; // CPU A15..A1, no A0 on a word bus
	typedef logic [DATA_W-1:0]    bus_data_t;
	typedef logic [BYTE_W-1:0]    byte_t;
	typedef logic [PAL_IDX_W-1:0] pal_idx_t;   // Shared by CPU and video side
	typedef logic [COLOR_W-1:0]   color5_t;

	// Region latched by the decoder on a read edge
	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_PALETTE,
		REGION_CTRL,
		REGION_INPUT
	} region_e;

	////////////////////////////////////////
	// Address map, upper nibble A15..A12
	////////////////////////////////////////

	localparam logic [3:0] PAL_NIBBLE   = 4'h5;
	localparam logic [3:0] CTRL_NIBBLE  = 4'h6;
	localparam logic [3:0] INPUT_NIBBLE = 4'h7;

	localparam bus_data_t OPEN_BUS = 16'hffff; // Pulled-up data lines

	// Control latch bit positions
	// Bits 0 and 1 are plain storage
	localparam int CTRL_HFLIP     = 2;
	localparam int CTRL_VFLIP     = 3;
	localparam int CTRL_WIDE      = 4; // 288 vs 256 pixel width
	localparam int CTRL_INTERLACE = 5;

endpackage

`default_nettype wire

//--- nemesis_bus_decode.sv
`default_nettype none

module nemesis_bus_decode import nemesis_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,

	input  logic       i_as_n,      // Address strobe
	input  logic       i_rw_n,      // High for read
	input  logic       i_uds_n,     // D15..D8 strobe
	input  logic       i_lds_n,     // D7..D0 strobe
	input  word_addr_t i_addr,

	input  bus_data_t  i_pal_rdata, // Synchronous palette word
	input  byte_t      i_io_rdata,  // Registered latch or input byte

	output logic       o_pal_we_hi,
	output logic       o_pal_we_lo,
	output logic       o_ctrl_we,
	output bus_data_t  o_rdata
);

	logic    wr_cyc;
	logic    rd_cyc;
	region_e region;    // Region of the current address
	region_e rd_region; // Region of the last read

	assign wr_cyc = ~i_as_n & ~i_rw_n;
	assign rd_cyc = ~i_as_n &  i_rw_n;

	////////////////////////////////////////
	// Region decode
	////////////////////////////////////////

	always_comb begin
		case (i_addr[15:12])
			PAL_NIBBLE:   region = REGION_PALETTE;
			CTRL_NIBBLE:  region = REGION_CTRL;
			INPUT_NIBBLE: region = REGION_INPUT;
			default:      region = REGION_NONE; // Open bus
		endcase
	end

	// Byte lanes only matter for the palette
	assign o_pal_we_hi = wr_cyc & (region == REGION_PALETTE) & ~i_uds_n;
	assign o_pal_we_lo = wr_cyc & (region == REGION_PALETTE) & ~i_lds_n;
	assign o_ctrl_we   = wr_cyc & (region == REGION_CTRL);  // Strobes ignored, like an LS259

	////////////////////////////////////////
	// Read data select
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst)
			rd_region <= REGION_NONE;
		else if (rd_cyc)
			rd_region <= region; // Held until the next read edge
	end

	// Sources are already registered on the read edge
	always_comb begin
		case (rd_region)
			REGION_PALETTE:           o_rdata = i_pal_rdata;
			REGION_CTRL, REGION_INPUT: o_rdata = {8'h00, i_io_rdata};
			default:                  o_rdata = OPEN_BUS;
		endcase
	end

	// Writes only happen inside a strobed bus cycle
	assert property (@(posedge i_clk) (o_pal_we_hi || o_pal_we_lo || o_ctrl_we) |-> !i_as_n);

endmodule

`default_nettype wire

//--- nemesis_io_regs.sv
`default_nettype none

module nemesis_io_regs import nemesis_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,

	input  logic       i_ctrl_we,
	input  word_addr_t i_addr,
	input  logic       i_wbit,      // D0 into the addressed latch bit
	input  byte_t      i_dip3,

	// Active-low controls
	input  logic       i_coin1,
	input  logic       i_coin2,
	input  logic       i_service,
	input  logic       i_1p_start,
	input  logic       i_2p_start,
	input  logic       i_1p_left,
	input  logic       i_1p_right,
	input  logic       i_1p_up,
	input  logic       i_1p_down,
	input  logic       i_1p_sp_pow,
	input  logic       i_1p_missile,
	input  logic       i_1p_shoot,
	input  logic       i_2p_left,
	input  logic       i_2p_right,
	input  logic       i_2p_up,
	input  logic       i_2p_down,
	input  logic       i_2p_sp_pow,
	input  logic       i_2p_missile,
	input  logic       i_2p_shoot,

	output byte_t      o_rdata,
	output logic       o_hflip,
	output logic       o_vflip,
	output logic       o_288_256,
	output logic       o_inter_non
);

	byte_t ctrl_q;  // Addressable control latch
	byte_t in_sys;  // Coins, service, starts
	byte_t in_p1;
	byte_t in_p2;
	byte_t in_word; // Selected by A2..A1

	// Optocouplers invert the controls on the board
	assign in_sys = {3'b000, ~i_2p_start, ~i_1p_start, ~i_service, ~i_coin2, ~i_coin1};
	assign in_p1  = {1'b0, ~i_1p_shoot, ~i_1p_missile, ~i_1p_sp_pow,
		~i_1p_down, ~i_1p_up, ~i_1p_right, ~i_1p_left};
	assign in_p2  = {1'b0, ~i_2p_shoot, ~i_2p_missile, ~i_2p_sp_pow,
		~i_2p_down, ~i_2p_up, ~i_2p_right, ~i_2p_left};

	always_comb begin
		case (i_addr[2:1])
			2'd0:    in_word = in_sys;
			2'd1:    in_word = in_p1;
			2'd2:    in_word = in_p2;
			default: in_word = i_dip3; // DIP bank, not inverted
		endcase
	end

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			ctrl_q  <= '0;
			o_rdata <= '0;
		end else begin
			if (i_ctrl_we)
				ctrl_q[i_addr[3:1]] <= i_wbit; // One bit per word address
			o_rdata <= (i_addr[15:12] == CTRL_NIBBLE) ? ctrl_q : in_word;
		end
	end

	assign o_hflip     = ctrl_q[CTRL_HFLIP];
	assign o_vflip     = ctrl_q[CTRL_VFLIP];
	assign o_288_256   = ctrl_q[CTRL_WIDE];
	assign o_inter_non = ctrl_q[CTRL_INTERLACE];

	// Video controls and read byte clear through reset
	assert property (@(posedge i_clk) i_rst |=>
		({o_hflip, o_vflip, o_288_256, o_inter_non} == 4'b0000 && o_rdata == '0));

endmodule

`default_nettype wire

//--- nemesis_palette_ram.sv
`default_nettype none

module nemesis_palette_ram import nemesis_pkg::*; (
	input  logic      i_clk,

	// CPU port
	input  logic      i_we_hi,
	input  logic      i_we_lo,
	input  pal_idx_t  i_cpu_idx,
	input  bus_data_t i_wdata,
	output bus_data_t o_cpu_rdata,

	// Video port, read only
	input  pal_idx_t  i_vid_idx,
	output bus_data_t o_vid_rdata
);

	////////////////////////////////////////
	// Storage
	////////////////////////////////////////

	// Two byte-wide banks, like the pair of 2128 chips
	byte_t mem_hi [PAL_WORDS];
	byte_t mem_lo [PAL_WORDS];

	// CPU side
	always_ff @(posedge i_clk) begin
		if (i_we_hi)
			mem_hi[i_cpu_idx] <= i_wdata[15:8];
		if (i_we_lo)
			mem_lo[i_cpu_idx] <= i_wdata[7:0];
		o_cpu_rdata <= {mem_hi[i_cpu_idx], mem_lo[i_cpu_idx]}; // Old data on a collision
	end

	// Video side, one clock behind the colour index
	always_ff @(posedge i_clk) begin
		o_vid_rdata <= {mem_hi[i_vid_idx], mem_lo[i_vid_idx]};
	end

	// An X index would scatter a write
	assert property (@(posedge i_clk) (i_we_hi || i_we_lo) |-> !$isunknown(i_cpu_idx));

endmodule

`default_nettype wire

//--- nemesis_rgb_out.sv
`default_nettype none

module nemesis_rgb_out import nemesis_pkg::*; (
	input  logic      i_clk,
	input  logic      i_rst,
	input  logic      i_cen6,   // Pixel clock enable
	input  bus_data_t i_color,  // Palette word, xBBBBBGGGGGRRRRR

	output color5_t   o_red,
	output color5_t   o_green,
	output color5_t   o_blue
);

	color5_t red;
	color5_t green;
	color5_t blue;

	assign red   = i_color[4:0];
	assign green = i_color[9:5];
	assign blue  = i_color[14:10]; // Bit 15 unused

	////////////////////////////////////////
	// Output register
	////////////////////////////////////////

	always_ff @(posedge i_clk) begin
		if (i_rst) begin
			o_red   <= '0;
			o_green <= '0;
			o_blue  <= '0;
		end else if (i_cen6) begin // Hold between pixels
			o_red   <= red;
			o_green <= green;
			o_blue  <= blue;
		end
	end

endmodule

`default_nettype wire

//--- nemesis_video_bus.sv
`default_nettype none

module nemesis_video_bus import nemesis_pkg::*; (
	input  logic       i_clk,
	input  logic       i_rst,

	// CPU bus
	input  logic       i_as_n,
	input  logic       i_rw_n,
	input  logic       i_uds_n,
	input  logic       i_lds_n,
	input  word_addr_t i_addr,
	input  bus_data_t  i_wdata,
	output bus_data_t  o_rdata,

	// Video side
	input  pal_idx_t   i_cd,        // Colour index from the video board
	input  logic       i_cen6,
	output color5_t    o_red,
	output color5_t    o_green,
	output color5_t    o_blue,
	output logic       o_hflip,
	output logic       o_vflip,
	output logic       o_288_256,
	output logic       o_inter_non,

	// Inputs
	input  byte_t      i_dip3,
	input  logic       i_coin1,
	input  logic       i_coin2,
	input  logic       i_service,
	input  logic       i_1p_start,
	input  logic       i_2p_start,
	input  logic       i_1p_left,
	input  logic       i_1p_right,
	input  logic       i_1p_up,
	input  logic       i_1p_down,
	input  logic       i_1p_sp_pow,
	input  logic       i_1p_missile,
	input  logic       i_1p_shoot,
	input  logic       i_2p_left,
	input  logic       i_2p_right,
	input  logic       i_2p_up,
	input  logic       i_2p_down,
	input  logic       i_2p_sp_pow,
	input  logic       i_2p_missile,
	input  logic       i_2p_shoot
);

	logic      pal_we_hi;
	logic      pal_we_lo;
	logic      ctrl_we;
	bus_data_t pal_rdata;  // CPU port read word
	bus_data_t vid_color;  // Video port read word
	byte_t     io_rdata;

	////////////////////////////////////////
	// Bus side
	////////////////////////////////////////

	nemesis_bus_decode u_decode (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_as_n      (i_as_n),
		.i_rw_n      (i_rw_n),
		.i_uds_n     (i_uds_n),
		.i_lds_n     (i_lds_n),
		.i_addr      (i_addr),
		.i_pal_rdata (pal_rdata),
		.i_io_rdata  (io_rdata),
		.o_pal_we_hi (pal_we_hi),
		.o_pal_we_lo (pal_we_lo),
		.o_ctrl_we   (ctrl_we),
		.o_rdata     (o_rdata)
	);

	nemesis_io_regs u_io (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_ctrl_we    (ctrl_we),
		.i_addr       (i_addr),
		.i_wbit       (i_wdata[0]),   // Latch data on D0
		.i_dip3       (i_dip3),
		.i_coin1      (i_coin1),
		.i_coin2      (i_coin2),
		.i_service    (i_service),
		.i_1p_start   (i_1p_start),
		.i_2p_start   (i_2p_start),
		.i_1p_left    (i_1p_left),
		.i_1p_right   (i_1p_right),
		.i_1p_up      (i_1p_up),
		.i_1p_down    (i_1p_down),
		.i_1p_sp_pow  (i_1p_sp_pow),
		.i_1p_missile (i_1p_missile),
		.i_1p_shoot   (i_1p_shoot),
		.i_2p_left    (i_2p_left),
		.i_2p_right   (i_2p_right),
		.i_2p_up      (i_2p_up),
		.i_2p_down    (i_2p_down),
		.i_2p_sp_pow  (i_2p_sp_pow),
		.i_2p_missile (i_2p_missile),
		.i_2p_shoot   (i_2p_shoot),
		.o_rdata      (io_rdata),
		.o_hflip      (o_hflip),
		.o_vflip      (o_vflip),
		.o_288_256    (o_288_256),
		.o_inter_non  (o_inter_non)
	);

	////////////////////////////////////////
	// Palette and colour out
	////////////////////////////////////////

	nemesis_palette_ram u_palette (
		.i_clk       (i_clk),
		.i_we_hi     (pal_we_hi),
		.i_we_lo     (pal_we_lo),
		.i_cpu_idx   (i_addr[11:1]),  // A11..A1
		.i_wdata     (i_wdata),
		.o_cpu_rdata (pal_rdata),
		.i_vid_idx   (i_cd),
		.o_vid_rdata (vid_color)
	);

	nemesis_rgb_out u_rgb (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_cen6  (i_cen6),
		.i_color (vid_color),
		.o_red   (o_red),
		.o_green (o_green),
		.o_blue  (o_blue)
	);

endmodule

`default_nettype wire

//--- tb_nemesis_model.svh
`ifndef TB_NEMESIS_MODEL_SVH
`define TB_NEMESIS_MODEL_SVH

////////////////////////////////////////
// Reference model
////////////////////////////////////////

bus_data_t pal_model [PAL_WORDS]; // Expected palette words
byte_t     ctrl_model;            // Expected control latch

// Lanes replaced where the strobe is low
function automatic bus_data_t merge_lanes(bus_data_t old_word, bus_data_t new_word,
		logic hi_n, logic lo_n);
	bus_data_t w;
	w = old_word;
	if (!hi_n)
		w[15:8] = new_word[15:8];
	if (!lo_n)
		w[7:0] = new_word[7:0];
	return w;
endfunction

// Controls read back inverted, DIP bank as is
function automatic bus_data_t input_word(logic [1:0] sel);
	case (sel)
		2'd0:    return {11'd0, ~sys_in};
		2'd1:    return {9'd0, ~p1_in};
		2'd2:    return {9'd0, ~p2_in};
		default: return {8'd0, dip3};
	endcase
endfunction

task automatic abort_run(string why);
	$display("%s", why);
	$display("CHECKS FAILED");
	$fatal(1, "Simulation stopped on the first failure");
endtask

task automatic word_compare(string name, bus_data_t exp, bus_data_t act);
	if (act !== exp)
		abort_run($sformatf("Error %s expected %h actual %h", name, exp, act));
endtask

task automatic byte_compare(string name, byte_t exp, byte_t act);
	if (act !== exp)
		abort_run($sformatf("Error %s expected %h actual %h", name, exp, act));
endtask

task automatic color_compare(string name, color5_t exp, color5_t act);
	if (act !== exp)
		abort_run($sformatf("Error %s expected %h actual %h", name, exp, act));
endtask

task automatic flag_compare(string name, logic exp, logic act);
	if (act !== exp)
		abort_run($sformatf("Error %s expected %b actual %b", name, exp, act));
endtask

////////////////////////////////////////
// Bus cycles
////////////////////////////////////////

// Taken by the DUT on the following rising edge
task automatic write_cycle(word_addr_t a, bus_data_t d, logic hi_n, logic lo_n);
	@(posedge clk);
	as_n  <= 1'b0;
	rw_n  <= 1'b0;
	uds_n <= hi_n;
	lds_n <= lo_n;
	addr  <= a;
	wdata <= d;
endtask

task automatic release_bus();
	@(posedge clk);
	as_n  <= 1'b1;
	rw_n  <= 1'b1;
	uds_n <= 1'b1;
	lds_n <= 1'b1;
endtask

// Word sampled mid-cycle, one clock after the read edge
task automatic read_cycle(word_addr_t a, output bus_data_t d);
	@(posedge clk);
	as_n  <= 1'b0;
	rw_n  <= 1'b1;
	uds_n <= 1'b0;
	lds_n <= 1'b0;
	addr  <= a;
	release_bus();
	@(negedge clk);
	d = rdata;
endtask

`endif

//--- tb_nemesis_video_bus.sv
`default_nettype none

module tb_nemesis_video_bus import nemesis_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_PAL  = 200;
	localparam int N_CTRL = 64;
	localparam int N_IN   = 32;
	localparam int N_RGB  = 32;
	localparam int N_OPEN = 64;
	// Cycles per test from the bus cycle lengths, with some slack
	localparam int TEST_CYCLES = 5 + PAL_WORDS + 4 + N_PAL * 4 + N_CTRL * 4
		+ N_IN * 13 + N_RGB * 12 + N_OPEN * 10;
	localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

	logic       clk = 1'b0;
	logic       rst;
	logic       as_n;
	logic       rw_n;
	logic       uds_n;
	logic       lds_n;
	word_addr_t addr;
	bus_data_t  wdata;
	bus_data_t  rdata;
	pal_idx_t   cd;
	logic       cen6;
	color5_t    red;
	color5_t    green;
	color5_t    blue;
	logic       hflip;
	logic       vflip;
	logic       wide;
	logic       inter;
	byte_t      dip3;
	logic [4:0] sys_in;   // Line levels, active low
	logic [6:0] p1_in;    // Left, right, up, down, sp_pow, missile, shoot
	logic [6:0] p2_in;
	int         cycles;

	`include "tb_nemesis_model.svh"

	always #10 clk = ~clk; // 20 ns period

	nemesis_video_bus dut_i (
		.i_clk (clk), .i_rst (rst),
		.i_as_n (as_n), .i_rw_n (rw_n), .i_uds_n (uds_n), .i_lds_n (lds_n),
		.i_addr (addr), .i_wdata (wdata), .o_rdata (rdata),
		.i_cd (cd), .i_cen6 (cen6),
		.o_red (red), .o_green (green), .o_blue (blue),
		.o_hflip (hflip), .o_vflip (vflip), .o_288_256 (wide), .o_inter_non (inter),
		.i_dip3 (dip3),
		.i_coin1 (sys_in[0]), .i_coin2 (sys_in[1]), .i_service (sys_in[2]),
		.i_1p_start (sys_in[3]), .i_2p_start (sys_in[4]),
		.i_1p_left (p1_in[0]), .i_1p_right (p1_in[1]), .i_1p_up (p1_in[2]),
		.i_1p_down (p1_in[3]), .i_1p_sp_pow (p1_in[4]), .i_1p_missile (p1_in[5]),
		.i_1p_shoot (p1_in[6]),
		.i_2p_left (p2_in[0]), .i_2p_right (p2_in[1]), .i_2p_up (p2_in[2]),
		.i_2p_down (p2_in[3]), .i_2p_sp_pow (p2_in[4]), .i_2p_missile (p2_in[5]),
		.i_2p_shoot (p2_in[6])
	);

	// Watchdog
	always @(posedge clk) begin
		if (rst)
			cycles <= 0;
		else begin
			cycles <= cycles + 1;
			if (cycles == CYCLE_LIMIT)
				abort_run($sformatf("Timeout after %0d cycles, tests did not finish", cycles));
		end
	end

	////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////

	initial begin
		bus_data_t  rd;
		bus_data_t  w;
		word_addr_t a;
		pal_idx_t   idx;
		logic [3:0] hi;
		logic [2:0] bit_sel;
		logic       hi_n;
		logic       lo_n;

		void'($urandom(32'h185730f4));
		rst    <= 1'b1;
		as_n   <= 1'b1;
		rw_n   <= 1'b1;
		uds_n  <= 1'b1;
		lds_n  <= 1'b1;
		addr   <= '0;
		wdata  <= '0;
		cd     <= '0;
		cen6   <= 1'b0;
		dip3   <= '0;
		sys_in <= '1;   // All released
		p1_in  <= '1;
		p2_in  <= '1;
		ctrl_model = '0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;

		// Reset state
		@(negedge clk);
		word_compare("reset rdata", OPEN_BUS, rdata);
		color_compare("reset red", '0, red);
		color_compare("reset green", '0, green);
		color_compare("reset blue", '0, blue);
		flag_compare("reset hflip", 1'b0, hflip);
		flag_compare("reset vflip", 1'b0, vflip);
		flag_compare("reset 288_256", 1'b0, wide);
		flag_compare("reset inter_non", 1'b0, inter);
		read_cycle({4'h0, 11'($urandom)}, rd);
		word_compare("reset open bus", OPEN_BUS, rd);

		// Known palette contents first
		for (int i = 0; i < PAL_WORDS; i++) begin
			idx = pal_idx_t'(i);
			w   = {idx[4:0], idx};
			write_cycle({PAL_NIBBLE, idx}, w, 1'b0, 1'b0);
			pal_model[idx] = w;
		end
		release_bus();

		// Palette byte writes
		for (int n = 0; n < N_PAL; n++) begin
			idx  = pal_idx_t'($urandom);
			w    = bus_data_t'($urandom);
			hi_n = 1'($urandom);
			lo_n = 1'($urandom);    // Both high means no write
			write_cycle({PAL_NIBBLE, idx}, w, hi_n, lo_n);
			pal_model[idx] = merge_lanes(pal_model[idx], w, hi_n, lo_n);
			read_cycle({PAL_NIBBLE, idx}, rd);
			word_compare("palette readback", pal_model[idx], rd);
		end

		// Control latch
		for (int n = 0; n < N_CTRL; n++) begin
			bit_sel = 3'($urandom);
			w       = bus_data_t'($urandom);
			write_cycle({CTRL_NIBBLE, 8'($urandom), bit_sel}, w, 1'($urandom), 1'($urandom));
			ctrl_model[bit_sel] = w[0];
			read_cycle({CTRL_NIBBLE, 11'($urandom)}, rd);
			byte_compare("control readback", ctrl_model, rd[7:0]);
			byte_compare("control upper byte", 8'h00, rd[15:8]);
			flag_compare("hflip", ctrl_model[CTRL_HFLIP], hflip);
			flag_compare("vflip", ctrl_model[CTRL_VFLIP], vflip);
			flag_compare("288_256", ctrl_model[CTRL_WIDE], wide);
			flag_compare("inter_non", ctrl_model[CTRL_INTERLACE], inter);
		end

		// Input port words
		for (int n = 0; n < N_IN; n++) begin
			@(posedge clk);
			sys_in <= 5'($urandom);
			p1_in  <= 7'($urandom);
			p2_in  <= 7'($urandom);
			dip3   <= byte_t'($urandom);
			for (int s = 0; s < 4; s++) begin
				read_cycle({INPUT_NIBBLE, 9'($urandom), 2'(s)}, rd);
				word_compare($sformatf("input word %0d", s), input_word(2'(s)), rd);
			end
		end

		// Video side colour out
		for (int n = 0; n < N_RGB; n++) begin
			idx = pal_idx_t'($urandom);
			w   = bus_data_t'($urandom);
			write_cycle({PAL_NIBBLE, idx}, w, 1'b0, 1'b0);
			pal_model[idx] = w;
			release_bus();
			@(posedge clk);
			cd <= idx;
			repeat (2) @(posedge clk); // Index held two clocks
			cen6 <= 1'b1;
			@(posedge clk);
			cen6 <= 1'b0;
			@(negedge clk);
			color_compare("red", pal_model[idx][4:0], red);
			color_compare("green", pal_model[idx][9:5], green);
			color_compare("blue", pal_model[idx][14:10], blue);
			repeat (3) begin
				@(posedge clk);
				cd <= pal_idx_t'($urandom); // Must not reach the outputs
			end
			@(posedge clk);
			@(negedge clk);
			color_compare("red hold", pal_model[idx][4:0], red);
			color_compare("green hold", pal_model[idx][9:5], green);
			color_compare("blue hold", pal_model[idx][14:10], blue);
		end

		// Unmapped space
		for (int n = 0; n < N_OPEN; n++) begin
			do
				hi = 4'($urandom);
			while (hi inside {PAL_NIBBLE, CTRL_NIBBLE, INPUT_NIBBLE});
			a = {hi, 11'($urandom)};
			read_cycle(a, rd);
			word_compare("open bus read", OPEN_BUS, rd);
			write_cycle(a, bus_data_t'($urandom), 1'b0, 1'b0);
			read_cycle({PAL_NIBBLE, a[11:1]}, rd);  // Same low index
			word_compare("palette after open write", pal_model[a[11:1]], rd);
			read_cycle({CTRL_NIBBLE, a[11:1]}, rd);
			word_compare("latch after open write", {8'h00, ctrl_model}, rd);
		end

		release_bus();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- nemesis_video_bus.f
+incdir+.
nemesis_pkg.sv
nemesis_bus_decode.sv
nemesis_io_regs.sv
nemesis_palette_ram.sv
nemesis_rgb_out.sv
nemesis_video_bus.sv
tb_nemesis_video_bus.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
	--top-module tb_nemesis_video_bus \
	-f nemesis_video_bus.f \
	&& ./obj_dir/Vtb_nemesis_video_bus \
	|| { echo "Simulation failed"; exit 1; }
